/* flashram.f */
flashram_pkg.sv
flashram_array.sv
flashram_engine.sv
flashram_ctrl.sv
flashram_top.sv
tb_flashram.sv

/* flashram_array.sv */
`timescale 1ns/1ps

module flashram_array #(
    parameter int pages = 16,
    localparam int pw = (pages > 1) ? $clog2(pages) : 1,
    localparam int aw = pw + 5,
    localparam int depth = pages * flashram_pkg::page_words
) (
    input  logic          sys,
    input  logic          wr_en,
    input  logic [aw-1:0] wr_addr,
    input  logic [31:0]   wr_data,
    input  logic [aw-1:0] rd_addr,
    output logic [31:0]   rd_data
);

    logic [31:0] mem [0:depth-1];

    // powers up erased.
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = 32'hffff_ffff;
        end
    end

    always_ff @(posedge sys) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data; // whole word replaced.
        end
    end

    always_ff @(posedge sys) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* flashram_ctrl.sv */
`timescale 1ns/1ps

module flashram_ctrl #(
    parameter int pages = 16,
    localparam int pw = (pages > 1) ? $clog2(pages) : 1,
    localparam int aw = pw + 5
) (
    input  logic                    sys,
    input  logic                    rst_n,
    input  logic                    request,
    input  flashram_pkg::bus_req_t  req,
    input  logic                    op_done,
    input  logic [4:0]              buf_addr,
    input  logic [31:0]             rd_data,
    output logic                    ack,
    output logic [15:0]             rdata,
    output flashram_pkg::flash_op_t op,
    output logic                    op_pending,
    output logic [31:0]             buf_rdata,
    output logic [aw-1:0]           rd_addr
);

    typedef enum logic {
        st_idle,
        st_wait
    } bus_state_t;

    bus_state_t          bus_state;
    flashram_pkg::mode_t mode;
    logic [3:0]          status;
    logic [7:0]          command;
    logic                erase_enabled;

    logic        accept;
    logic        buf_we_high;
    logic        buf_we_low;
    logic [15:0] high_half;
    logic [31:0] wbuf [0:flashram_pkg::page_words-1];

    // what the acknowledged access looked like.
    logic       ack_write;
    logic       ack_window;
    logic [1:0] ack_half;

    assign accept = request && bus_state == st_idle;

    always_comb begin
        buf_we_high = 1'b0;
        buf_we_low  = 1'b0;
        if (accept && req.write && !req.address[16] && !op_pending &&
                mode == flashram_pkg::mode_buffer) begin
            buf_we_high = !req.address[1];
            buf_we_low  = req.address[1];
        end
    end

    // high halfword waits for its low partner.
    always_ff @(posedge sys) begin
        if (buf_we_high) high_half <= req.wdata;
    end

    always_ff @(posedge sys) begin
        buf_rdata <= wbuf[buf_addr]; // engine read port.
        if (buf_we_low) begin
            wbuf[req.address[6:2]] <= {high_half, req.wdata};
        end
    end

    always_ff @(posedge sys) begin
        if (accept) begin
            ack_write  <= req.write;
            ack_window <= req.address[16];
            ack_half   <= req.address[2:1];
        end
    end

    assign rd_addr = req.address[aw+1:2]; // word address, array registers it.

    always_comb begin
        rdata = 16'd0;
        if (ack && !ack_write && !ack_window) begin
            case (mode)
                flashram_pkg::mode_status: begin
                    if (ack_half[0]) rdata = {12'd0, status};
                end
                flashram_pkg::mode_id: begin
                    case (ack_half)
                        2'd0: rdata = flashram_pkg::flash_type_id[31:16];
                        2'd1: rdata = flashram_pkg::flash_type_id[15:0];
                        2'd2: rdata = flashram_pkg::flash_model_id[31:16];
                        default: rdata = flashram_pkg::flash_model_id[15:0];
                    endcase
                end
                flashram_pkg::mode_read: begin
                    rdata = ack_half[0] ? rd_data[15:0] : rd_data[31:16];
                end
                default: rdata = 16'd0;
            endcase
        end
    end

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            bus_state     <= st_idle;
            ack           <= 1'b0;
            mode          <= flashram_pkg::mode_status;
            status        <= 4'b0000;
            command       <= 8'd0;
            erase_enabled <= 1'b0;
            op_pending    <= 1'b0;
            op            <= '0;
        end else begin
            ack <= 1'b0;

            if (op_done) begin
                op_pending <= 1'b0;
                if (op.write_or_erase) begin
                    status[flashram_pkg::st_erase_busy] <= 1'b0;
                    status[flashram_pkg::st_erase_done] <= 1'b1;
                end else begin
                    status[flashram_pkg::st_write_busy] <= 1'b0;
                    status[flashram_pkg::st_write_done] <= 1'b1;
                end
            end

            case (bus_state)
                st_idle: begin
                    if (request) begin
                        bus_state <= st_wait;
                        ack       <= 1'b1;
                        if (req.write && !op_pending) begin
                            if (req.address[16]) begin
                                if (!req.address[1]) begin
                                    command <= req.wdata[15:8]; // latched only.
                                end else begin
                                    erase_enabled <= 1'b0; // any execute disarms erase.
                                    case (command)
                                        flashram_pkg::cmd_status_mode: begin
                                            mode <= flashram_pkg::mode_status;
                                        end
                                        flashram_pkg::cmd_readid_mode: begin
                                            mode <= flashram_pkg::mode_id;
                                        end
                                        flashram_pkg::cmd_read_mode: begin
                                            mode <= flashram_pkg::mode_read;
                                        end
                                        flashram_pkg::cmd_buffer_mode: begin
                                            mode <= flashram_pkg::mode_buffer;
                                        end
                                        flashram_pkg::cmd_erase_sector: begin
                                            mode             <= flashram_pkg::mode_status;
                                            erase_enabled    <= 1'b1;
                                            op.sector        <= req.wdata[9:0];
                                            op.sector_or_all <= 1'b0;
                                        end
                                        flashram_pkg::cmd_erase_chip: begin
                                            mode             <= flashram_pkg::mode_status;
                                            erase_enabled    <= 1'b1;
                                            op.sector        <= 10'd0;
                                            op.sector_or_all <= 1'b1;
                                        end
                                        flashram_pkg::cmd_erase_start: begin
                                            mode <= flashram_pkg::mode_status;
                                            if (erase_enabled) begin
                                                status[flashram_pkg::st_erase_busy] <= 1'b1;
                                                status[flashram_pkg::st_erase_done] <= 1'b0;
                                                op.write_or_erase <= 1'b1;
                                                op_pending        <= 1'b1;
                                            end
                                        end
                                        flashram_pkg::cmd_write_start: begin
                                            mode <= flashram_pkg::mode_status;
                                            status[flashram_pkg::st_write_busy] <= 1'b1;
                                            status[flashram_pkg::st_write_done] <= 1'b0;
                                            op.sector         <= req.wdata[9:0];
                                            op.write_or_erase <= 1'b0;
                                            op.sector_or_all  <= 1'b0;
                                            op_pending        <= 1'b1;
                                        end
                                        default: ; // unknown codes do nothing.
                                    endcase
                                end
                            end else if (mode == flashram_pkg::mode_status) begin
                                // host clears the done flags by writing zeros.
                                status[flashram_pkg::st_erase_done] <=
                                    req.wdata[flashram_pkg::st_erase_done];
                                status[flashram_pkg::st_write_done] <=
                                    req.wdata[flashram_pkg::st_write_done];
                            end
                        end
                    end
                end
                st_wait: begin
                    bus_state <= st_idle;
                end
                default: bus_state <= st_idle;
            endcase
        end
    end

endmodule

/* flashram_engine.sv */
`timescale 1ns/1ps

module flashram_engine #(
    parameter int pages = 16,
    localparam int pw = (pages > 1) ? $clog2(pages) : 1,
    localparam int aw = pw + 5
) (
    input  logic                    sys,
    input  logic                    rst_n,
    input  flashram_pkg::flash_op_t op,
    input  logic                    op_pending,
    input  logic [31:0]             buf_rdata,
    output logic                    op_done,
    output logic [4:0]              buf_addr,
    output logic                    wr_en,
    output logic [aw-1:0]           wr_addr,
    output logic [31:0]             wr_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } eng_state_t;

    eng_state_t    state;
    logic [5:0]    cnt;  // word step, runs one further for page writes.
    logic [pw-1:0] page;
    logic          last;
    logic [4:0]    word;

    // writes trail the buffer address by one cycle.
    assign word     = op.write_or_erase ? cnt[4:0] : cnt[4:0] - 5'd1;
    assign buf_addr = cnt[4:0];
    assign wr_en    = state == st_run && (op.write_or_erase || cnt != 6'd0);
    assign wr_addr  = {page, word};
    assign wr_data  = op.write_or_erase ? 32'hffff_ffff : buf_rdata;

    always_comb begin
        if (op.write_or_erase) begin
            last = cnt == 6'(flashram_pkg::page_words - 1) &&
                   (!op.sector_or_all || page == pw'(pages - 1));
        end else begin
            last = cnt == 6'(flashram_pkg::page_words);
        end
    end

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            cnt     <= 6'd0;
            page    <= '0;
            op_done <= 1'b0;
        end else begin
            op_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (op_pending) begin
                        state <= st_run;
                        cnt   <= 6'd0;
                        page  <= op.sector_or_all ? '0 : op.sector[pw-1:0]; // high bits wrap.
                    end
                end
                st_run: begin
                    if (last) begin
                        state   <= st_done;
                        op_done <= 1'b1;
                    end else if (op.write_or_erase &&
                                 cnt == 6'(flashram_pkg::page_words - 1)) begin
                        cnt  <= 6'd0; // next page of a chip erase.
                        page <= page + 1'b1;
                    end else begin
                        cnt <= cnt + 6'd1;
                    end
                end
                st_done: begin
                    state <= st_idle; // pending drops on this edge.
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* flashram_pkg.sv */
package flashram_pkg;

    // host command codes, written to the high byte of register halfword 0.
    typedef enum logic [7:0] {
        cmd_status_mode  = 8'hd2,
        cmd_readid_mode  = 8'he1,
        cmd_read_mode    = 8'hf0,
        cmd_erase_sector = 8'h4b,
        cmd_erase_chip   = 8'h3c,
        cmd_buffer_mode  = 8'hb4,
        cmd_erase_start  = 8'h78,
        cmd_write_start  = 8'ha5
    } cmd_t;

    localparam logic [31:0] flash_type_id  = 32'h1111_8001;
    localparam logic [31:0] flash_model_id = 32'h00c2_001d;

    // bit positions inside the 4-bit status register.
    typedef enum logic [1:0] {
        st_write_busy = 2'd0,
        st_erase_busy = 2'd1,
        st_write_done = 2'd2,
        st_erase_done = 2'd3
    } status_bit_t;

    typedef enum logic [1:0] {
        mode_status,
        mode_id,
        mode_read,
        mode_buffer
    } mode_t;

    // one host access, valid with the request strobe.
    typedef struct packed {
        logic        write;
        logic [16:0] address; // byte address, bit 16 is the register window.
        logic [15:0] wdata;
    } bus_req_t;

    // operation handed to the engine.
    typedef struct packed {
        logic [9:0] sector;
        logic       write_or_erase; // set for erase.
        logic       sector_or_all;  // set for chip erase.
    } flash_op_t;

    // 32-bit words in one 128-byte page.
    localparam int page_words = 32;

endpackage

/* flashram_top.sv */
`timescale 1ns/1ps

module flashram_top #(
    parameter int pages = 16,
    localparam int pw = (pages > 1) ? $clog2(pages) : 1,
    localparam int aw = pw + 5
) (
    input  logic                   sys,
    input  logic                   rst_n,
    input  logic                   request,
    input  flashram_pkg::bus_req_t req,
    output logic                   ack,
    output logic [15:0]            rdata
);

    flashram_pkg::flash_op_t op;
    logic                    op_pending;
    logic                    op_done;
    logic [4:0]              buf_addr;
    logic [31:0]             buf_rdata;
    logic                    wr_en;
    logic [aw-1:0]           wr_addr;
    logic [31:0]             wr_data;
    logic [aw-1:0]           rd_addr;
    logic [31:0]             rd_data;

    flashram_ctrl #(.pages(pages)) u_ctrl (
        .sys        (sys),
        .rst_n      (rst_n),
        .request    (request),
        .req        (req),
        .op_done    (op_done),
        .buf_addr   (buf_addr),
        .rd_data    (rd_data),
        .ack        (ack),
        .rdata      (rdata),
        .op         (op),
        .op_pending (op_pending),
        .buf_rdata  (buf_rdata),
        .rd_addr    (rd_addr)
    );

    flashram_engine #(.pages(pages)) u_engine (
        .sys        (sys),
        .rst_n      (rst_n),
        .op         (op),
        .op_pending (op_pending),
        .buf_rdata  (buf_rdata),
        .op_done    (op_done),
        .buf_addr   (buf_addr),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    flashram_array #(.pages(pages)) u_array (
        .sys     (sys),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the flashram testbench with verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_flashram \
    -Mdir "$obj" -o tb_flashram -f flashram.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/tb_flashram" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# the log decides the result.
if grep -q "sim failed" "$log"; then
    exit 1
fi
exit 0

/* tb_flashram.sv */
`timescale 1ns/1ps

module tb_flashram;

    localparam int pages = 16;
    localparam int period = 8;
    // chip erase with its 1024 verify reads is the longest test at a few thousand cycles.
    localparam int watchdog_cycles = 40000;
    localparam int poll_limit = 400;
    localparam logic [16:0] reg_cmd     = 17'h1_0000;
    localparam logic [16:0] reg_exec    = 17'h1_0002;
    localparam logic [16:0] status_addr = 17'h0_0002;

    logic                   sys;
    logic                   rst_n;
    logic                   request;
    flashram_pkg::bus_req_t req;
    logic                   ack;
    logic [15:0]            rdata;

    int          errors;
    int          tests;
    logic [15:0] lfsr;
    logic [15:0] page_data [0:63]; // last page written through the buffer.

    flashram_top #(.pages(pages)) uut (
        .sys     (sys),
        .rst_n   (rst_n),
        .request (request),
        .req     (req),
        .ack     (ack),
        .rdata   (rdata)
    );

    initial begin
        sys = 1'b0;
        forever #(period / 2) sys = ~sys;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    function automatic logic [15:0] next_half();
        logic [15:0] value;
        value = 16'd0;
        for (int i = 0; i < 16; i++) begin
            value = {value[14:0], lfsr[0]}; // one step per bit.
            lfsr  = lfsr_step(lfsr);
        end
        return value;
    endfunction

    function automatic logic [16:0] data_address(input int page, input int half);
        return 17'(page * 128 + half * 2);
    endfunction

    task automatic report_mismatch(input string test, input logic [15:0] expected,
                                   input logic [15:0] actual);
        errors++;
        $display("Fail %s expected %h actual %h at %0t", test, expected, actual, $time);
    endtask

    task automatic bus_access(input logic is_write, input logic [16:0] address,
                              input logic [15:0] wdata, output logic [15:0] data);
        int waited;
        waited = 0;
        @(posedge sys);
        request     <= 1'b1;
        req.write   <= is_write;
        req.address <= address;
        req.wdata   <= wdata;
        @(posedge sys);
        request <= 1'b0;
        @(negedge sys);
        while (!ack && waited < 4) begin
            waited++;
            @(negedge sys);
        end
        data = rdata; // only valid with ack.
        if (!ack) begin
            errors++;
            $display("no ack for the access to address %h at %0t", address, $time);
        end else if (waited != 0) begin
            errors++;
            $display("late ack for address %h after %0d extra cycles", address, waited);
        end
    endtask

    task automatic bus_write(input logic [16:0] address, input logic [15:0] wdata);
        logic [15:0] unused;
        bus_access(1'b1, address, wdata, unused);
    endtask

    task automatic bus_read(input logic [16:0] address, output logic [15:0] data);
        bus_access(1'b0, address, 16'd0, data);
    endtask

    task automatic send_command(input flashram_pkg::cmd_t cmd, input logic [9:0] arg);
        bus_write(reg_cmd, {cmd, 8'h00});
        bus_write(reg_exec, {6'd0, arg});
    endtask

    task automatic poll_done(input int bit_pos, output logic [15:0] st);
        int polls;
        polls = 0;
        bus_read(status_addr, st);
        while (!st[bit_pos] && polls < poll_limit) begin
            polls++;
            bus_read(status_addr, st);
        end
        if (!st[bit_pos]) begin
            errors++;
            $display("status bit %0d never set within %0d polls", bit_pos, poll_limit);
        end
    endtask

    // program a random page through the buffer and leave the device in status mode.
    task automatic fill_page(input string test, input int page);
        logic [15:0] st;
        send_command(flashram_pkg::cmd_buffer_mode, 10'd0);
        for (int i = 0; i < 64; i++) begin
            page_data[i] = next_half();
            bus_write(data_address(0, i), page_data[i]);
        end
        send_command(flashram_pkg::cmd_write_start, 10'(page));
        poll_done(2, st);
        if (st[1:0] !== 2'b00) report_mismatch(test, 16'd0, {14'd0, st[1:0]});
    endtask

    task automatic check_page(input string test, input int page, input logic erased);
        logic [15:0] data;
        logic [15:0] expected;
        for (int i = 0; i < 64; i++) begin
            bus_read(data_address(page, i), data);
            expected = erased ? 16'hffff : page_data[i];
            if (data !== expected) report_mismatch(test, expected, data);
        end
    endtask

    task automatic reset_and_id();
        logic [15:0] data;
        logic [15:0] id_words [0:3];
        id_words[0] = 16'h1111;
        id_words[1] = 16'h8001;
        id_words[2] = 16'h00c2;
        id_words[3] = 16'h001d;
        tests++;
        bus_read(status_addr, data);
        if (data !== 16'd0) report_mismatch("reset_and_id", 16'd0, data);
        send_command(flashram_pkg::cmd_readid_mode, 10'd0);
        for (int i = 0; i < 4; i++) begin
            bus_read(data_address(0, i), data);
            if (data !== id_words[i]) report_mismatch("reset_and_id", id_words[i], data);
        end
        @(negedge sys);
        if (ack !== 1'b0) begin
            errors++;
            $display("ack stayed high for more than one cycle at %0t", $time);
        end
        if (rdata !== 16'd0) report_mismatch("reset_and_id", 16'd0, rdata);
    endtask

    task automatic page_write();
        tests++;
        fill_page("page_write", 3);
        send_command(flashram_pkg::cmd_read_mode, 10'd0);
        check_page("page_write", 3, 1'b0);
        check_page("page_write", 2, 1'b1); // neighbour stays erased.
    endtask

    task automatic sector_erase();
        logic [15:0] st;
        tests++;
        send_command(flashram_pkg::cmd_erase_sector, 10'd3);
        send_command(flashram_pkg::cmd_erase_start, 10'd0);
        poll_done(3, st);
        if (st[1] !== 1'b0) report_mismatch("sector_erase", 16'd0, {15'd0, st[1]});
        send_command(flashram_pkg::cmd_read_mode, 10'd0);
        check_page("sector_erase", 3, 1'b1);
    endtask

    task automatic unarmed_erase();
        logic [15:0] st;
        tests++;
        fill_page("unarmed_erase", 5);
        bus_read(status_addr, st);
        if (st !== 16'h000c) report_mismatch("unarmed_erase", 16'h000c, st);
        send_command(flashram_pkg::cmd_erase_start, 10'd5);
        bus_read(status_addr, st);
        if (st !== 16'h000c) report_mismatch("unarmed_erase", 16'h000c, st);
        send_command(flashram_pkg::cmd_read_mode, 10'd0);
        check_page("unarmed_erase", 5, 1'b0);
        send_command(flashram_pkg::cmd_status_mode, 10'd0);
        bus_write(data_address(0, 0), 16'd0); // clears both done bits.
        bus_read(status_addr, st);
        if (st !== 16'd0) report_mismatch("unarmed_erase", 16'd0, st);
    endtask

    task automatic chip_erase();
        logic [15:0] st;
        tests++;
        fill_page("chip_erase", 0);
        send_command(flashram_pkg::cmd_read_mode, 10'd0);
        check_page("chip_erase", 0, 1'b0);
        fill_page("chip_erase", 9);
        send_command(flashram_pkg::cmd_read_mode, 10'd0);
        check_page("chip_erase", 9, 1'b0);
        send_command(flashram_pkg::cmd_erase_chip, 10'd0);
        send_command(flashram_pkg::cmd_erase_start, 10'd0);
        // ignored while the erase runs so status stays readable.
        send_command(flashram_pkg::cmd_readid_mode, 10'd0);
        bus_read(status_addr, st);
        if (st !== 16'h0006) report_mismatch("chip_erase", 16'h0006, st);
        poll_done(3, st);
        if (st[1] !== 1'b0) report_mismatch("chip_erase", 16'd0, {15'd0, st[1]});
        send_command(flashram_pkg::cmd_read_mode, 10'd0);
        for (int p = 0; p < pages; p++) begin
            check_page("chip_erase", p, 1'b1);
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge sys);
        $display("timeout, the run did not finish within %0d cycles", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n   <= 1'b0;
        request <= 1'b0;
        req     <= '0;
        errors = 0;
        tests  = 0;
        lfsr   = 16'd29;
        repeat (16) @(posedge sys);
        rst_n <= 1'b1;
        repeat (2) @(posedge sys);

        reset_and_id();
        page_write();
        sector_erase();
        unarmed_erase();
        chip_erase();

        $display("tests %0d errors %0d", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
